// File: verilog.f
design/alu_pkg.sv
design/stage_if.sv
design/alu_slice.sv
design/carry_lookahead.sv
design/operand_stage.sv
design/slice_stage.sv
design/flag_stage.sv
design/alu_pipe.sv
sim/alu_pipe_tb.sv

// File: run.sh
#!/bin/sh
# Builds the testbench with Verilator and runs it from the project root.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module alu_pipe_tb -o alu_pipe_tb -f verilog.f
status=$?
if [ $status -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit $status
fi

./obj_dir/alu_pipe_tb
status=$?
if [ $status -ne 0 ]; then
  echo "Simulation failed with status $status"
  exit $status
fi

exit 0

// File: sim/alu_pipe_tb.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe_tb import alu_pkg::*;;

  localparam int NUM_SLICES  = 4;
  localparam int WIDTH       = NUM_SLICES * SLICE_WIDTH;
  localparam int NUM_OPS     = 2000;
  localparam int DRAIN_LIMIT = 20;

  logic             clk;
  logic             rst;
  logic             in_valid;
  alu_op_t          in_op;
  logic [WIDTH-1:0] in_a;
  logic [WIDTH-1:0] in_b;
  logic             out_valid;
  logic [WIDTH-1:0] out_result;
  alu_flags_t       out_flags;

  integer           seed;
  integer           ops_sent;
  logic [2:0]       vld_pipe;
  logic [WIDTH+3:0] exp_q[$];

  alu_pipe #(
    .NUM_SLICES (NUM_SLICES)
  ) i_alu_pipe (
    .clk        (clk),
    .rst        (rst),
    .in_valid   (in_valid),
    .in_op      (in_op),
    .in_a       (in_a),
    .in_b       (in_b),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_flags  (out_flags)
  );

  initial clk = 1'b0;
  always #2 clk = ~clk;

  // The model returns the expected flags above the expected result.
  function automatic logic [WIDTH+3:0] model_op(alu_op_t op, logic [WIDTH-1:0] a,
                                                logic [WIDTH-1:0] b);
    logic [WIDTH:0]   sum;
    logic [WIDTH-1:0] res;
    alu_flags_t       f;
    sum = '0;
    res = '0;
    f   = '0;
    case (op)
      alu_add: begin
        sum        = {1'b0, a} + {1'b0, b};
        res        = sum[WIDTH-1:0];
        f.carry    = sum[WIDTH];
        f.overflow = (a[WIDTH-1] == b[WIDTH-1]) && (res[WIDTH-1] != a[WIDTH-1]);
      end
      alu_sub: begin
        sum        = {1'b0, a} + {1'b0, ~b} + (WIDTH+1)'(1);
        res        = sum[WIDTH-1:0];
        f.carry    = sum[WIDTH];
        // A difference overflows when the operand signs differ and the sign of a flips.
        f.overflow = (a[WIDTH-1] != b[WIDTH-1]) && (res[WIDTH-1] != a[WIDTH-1]);
      end
      alu_and: res = a & b;
      alu_or:  res = a | b;
      alu_xor: res = a ^ b;
      alu_not: res = ~a;
      default: res = '0;
    endcase
    f.zero     = (res == '0);
    f.negative = res[WIDTH-1];
    return {f, res};
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] exp_val,
                                 input logic [31:0] act_val);
    $display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp_val, act_val);
    $display("TEST FAIL");
    $fatal(1);
  endtask

  // Called on the falling edge, where the DUT outputs are settled.
  task automatic check_outputs();
    logic [WIDTH+3:0] entry;
    alu_flags_t       exp_f;
    logic [WIDTH-1:0] exp_r;
    assert (out_valid === vld_pipe[2])
      else report_mismatch("out_valid", 32'(vld_pipe[2]), 32'(out_valid));
    if (out_valid) begin
      entry = exp_q.pop_front();
      exp_f = alu_flags_t'(entry[WIDTH+3:WIDTH]);
      exp_r = entry[WIDTH-1:0];
      assert (out_result === exp_r)
        else report_mismatch("out_result", 32'(exp_r), 32'(out_result));
      assert (out_flags.zero === exp_f.zero)
        else report_mismatch("out_flags.zero", 32'(exp_f.zero), 32'(out_flags.zero));
      assert (out_flags.carry === exp_f.carry)
        else report_mismatch("out_flags.carry", 32'(exp_f.carry), 32'(out_flags.carry));
      assert (out_flags.negative === exp_f.negative)
        else report_mismatch("out_flags.negative", 32'(exp_f.negative),
                             32'(out_flags.negative));
      assert (out_flags.overflow === exp_f.overflow)
        else report_mismatch("out_flags.overflow", 32'(exp_f.overflow),
                             32'(out_flags.overflow));
    end
  endtask

  task automatic step(input logic valid, input alu_op_t op, input logic [WIDTH-1:0] a,
                      input logic [WIDTH-1:0] b);
    in_valid = valid;
    in_op    = op;
    in_a     = a;
    in_b     = b;
    vld_pipe = {vld_pipe[1:0], valid};
    if (valid) begin
      exp_q.push_back(model_op(op, a, b));
      ops_sent = ops_sent + 1;
    end
  endtask

  task automatic run_directed(input alu_op_t op, input logic [WIDTH-1:0] a,
                              input logic [WIDTH-1:0] b);
    @(negedge clk);
    check_outputs();
    step(1'b1, op, a, b);
  endtask

  initial begin
    logic [31:0]      rnd;
    logic [WIDTH-1:0] ra;
    logic [WIDTH-1:0] rb;
    alu_op_t          rop;
    int               waited;
    seed     = 32'h1e07;
    rst      = 1'b1;
    in_valid = 1'b0;
    in_op    = alu_nop0;
    in_a     = '0;
    in_b     = '0;
    vld_pipe = '0;
    ops_sent = 0;

    repeat (2) begin
      @(negedge clk);
      check_outputs();
    end
    rst = 1'b0;

    // Carries across slice boundaries, equal operands and signed overflow corners.
    run_directed(alu_sub, 16'h1234, 16'h1234);
    run_directed(alu_add, 16'hffff, 16'h0001);
    run_directed(alu_add, 16'h0fff, 16'h0001);
    run_directed(alu_add, 16'h00ff, 16'h0001);
    run_directed(alu_add, 16'h000f, 16'h0001);
    run_directed(alu_add, 16'h7fff, 16'h0001);
    run_directed(alu_sub, 16'h8000, 16'h0001);
    run_directed(alu_sub, 16'h0000, 16'h0001);
    run_directed(alu_add, 16'h8000, 16'h8000);
    run_directed(alu_not, 16'hffff, 16'h0000);
    run_directed(alu_nop1, 16'hffff, 16'hffff);

    while (ops_sent < NUM_OPS) begin
      @(negedge clk);
      check_outputs();
      rnd = $random(seed);
      if (rnd[3:0] < 4'd3) begin
        step(1'b0, alu_nop0, '0, '0);
      end else begin
        rop = alu_op_t'(rnd[6:4]);
        rnd = $random(seed);
        ra  = rnd[WIDTH-1:0];
        rb  = rnd[31:32-WIDTH];
        // Some operand pairs are chosen to make long carry chains.
        if (rnd[9:8] == 2'd0) begin
          rb = ~ra;
        end else if (rnd[9:8] == 2'd1) begin
          rb = ra;
        end
        step(1'b1, rop, ra, rb);
      end
    end

    waited = 0;
    while ((exp_q.size() != 0 || vld_pipe != 3'b000) && waited < DRAIN_LIMIT) begin
      @(negedge clk);
      check_outputs();
      step(1'b0, alu_nop0, '0, '0);
      waited = waited + 1;
    end

    if (exp_q.size() != 0) begin
      $display("Results stopped arriving with %0d operations still pending", exp_q.size());
      $display("TEST FAIL");
      $fatal(1);
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: design/alu_pipe.sv
`timescale 1ns/1ps
`default_nettype none

module alu_pipe import alu_pkg::*; #(
  parameter int NUM_SLICES = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              in_valid,
  input  alu_op_t                           in_op,
  input  logic [NUM_SLICES*SLICE_WIDTH-1:0] in_a,
  input  logic [NUM_SLICES*SLICE_WIDTH-1:0] in_b,
  output logic                              out_valid,
  output logic [NUM_SLICES*SLICE_WIDTH-1:0] out_result,
  output alu_flags_t                        out_flags
);

  op_if #(.NUM_SLICES(NUM_SLICES)) op_bus ();
  result_if #(.NUM_SLICES(NUM_SLICES)) res_bus ();

  operand_stage #(
    .NUM_SLICES (NUM_SLICES)
  ) i_operand_stage (
    .clk      (clk),
    .rst      (rst),
    .in_valid (in_valid),
    .in_op    (in_op),
    .in_a     (in_a),
    .in_b     (in_b),
    .down     (op_bus.src)
  );

  slice_stage #(
    .NUM_SLICES (NUM_SLICES)
  ) i_slice_stage (
    .clk  (clk),
    .rst  (rst),
    .up   (op_bus.dst),
    .down (res_bus.src)
  );

  flag_stage #(
    .NUM_SLICES (NUM_SLICES)
  ) i_flag_stage (
    .clk        (clk),
    .rst        (rst),
    .up         (res_bus.dst),
    .out_valid  (out_valid),
    .out_result (out_result),
    .out_flags  (out_flags)
  );

endmodule

`default_nettype wire

// File: design/flag_stage.sv
`timescale 1ns/1ps
`default_nettype none

module flag_stage import alu_pkg::*; #(
  parameter int NUM_SLICES = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  result_if.dst                             up,
  output logic                              out_valid,
  output logic [NUM_SLICES*SLICE_WIDTH-1:0] out_result,
  output alu_flags_t                        out_flags
);

  localparam int WIDTH = NUM_SLICES * SLICE_WIDTH;

  logic       arith;
  logic       res_msb;
  alu_flags_t flags;

  assign arith   = is_arith(up.op);
  assign res_msb = up.result[WIDTH-1];

  always_comb begin
    flags.zero     = &up.slice_zero;
    flags.carry    = arith & up.carry_out;
    flags.negative = res_msb;
    // Signed overflow means operands of one sign gave a result of the other.
    flags.overflow = arith & (up.a_msb == up.b_msb) & (up.a_msb != res_msb);
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      out_valid <= 1'b0;
      out_flags <= '0;
    end else begin
      out_valid <= up.valid;
      out_flags <= flags;
    end
  end

  always_ff @(posedge clk) begin
    out_result <= up.result;
  end

endmodule

`default_nettype wire

// File: design/slice_stage.sv
`timescale 1ns/1ps
`default_nettype none

module slice_stage import alu_pkg::*; #(
  parameter int NUM_SLICES = 4
) (
  input  logic clk,
  input  logic rst,
  op_if.dst    up,
  result_if.src down
);

  localparam int WIDTH = NUM_SLICES * SLICE_WIDTH;

  logic              is_sub;
  logic [WIDTH-1:0]  b_eff;
  logic [WIDTH-1:0]  slice_out;
  logic [NUM_SLICES-1:0] prop;
  logic [NUM_SLICES-1:0] gen;
  logic [NUM_SLICES-1:0] zero;
  logic [NUM_SLICES:0]   carry;

  assign is_sub = (up.op == alu_sub);
  assign b_eff  = is_sub ? ~up.b : up.b;

  for (genvar i = 0; i < NUM_SLICES; i++) begin : g_slice
    alu_slice i_alu_slice (
      .a    (up.a[i*SLICE_WIDTH +: SLICE_WIDTH]),
      .b    (up.b[i*SLICE_WIDTH +: SLICE_WIDTH]),
      .op   (up.op),
      .c_in (carry[i]),
      .out  (slice_out[i*SLICE_WIDTH +: SLICE_WIDTH]),
      .prop (prop[i]),
      .gen  (gen[i]),
      .zero (zero[i])
    );
  end

  // The +1 of two's-complement subtraction enters at the bottom slice.
  carry_lookahead #(
    .NUM_SLICES (NUM_SLICES)
  ) i_carry_lookahead (
    .prop     (prop),
    .gen      (gen),
    .carry_in (is_sub),
    .carry    (carry)
  );

  always_ff @(posedge clk) begin
    if (rst) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= up.valid;
    end
  end

  always_ff @(posedge clk) begin
    down.op         <= up.op;
    down.result     <= slice_out;
    down.carry_out  <= carry[NUM_SLICES];
    down.slice_zero <= zero;
    down.a_msb      <= up.a[WIDTH-1];
    down.b_msb      <= b_eff[WIDTH-1];
  end

endmodule

`default_nettype wire

// File: design/operand_stage.sv
`timescale 1ns/1ps
`default_nettype none

module operand_stage import alu_pkg::*; #(
  parameter int NUM_SLICES = 4
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic                              in_valid,
  input  alu_op_t                           in_op,
  input  logic [NUM_SLICES*SLICE_WIDTH-1:0] in_a,
  input  logic [NUM_SLICES*SLICE_WIDTH-1:0] in_b,
  op_if.src                                 down
);

  always_ff @(posedge clk) begin
    if (rst) begin
      down.valid <= 1'b0;
    end else begin
      down.valid <= in_valid;
    end
  end

  // Payload only loads on a valid strobe, so idle cycles keep the last operands.
  always_ff @(posedge clk) begin
    if (in_valid) begin
      down.op <= in_op;
      down.a  <= in_a;
      down.b  <= in_b;
    end
  end

endmodule

`default_nettype wire

// File: design/carry_lookahead.sv
`timescale 1ns/1ps
`default_nettype none

module carry_lookahead #(
  parameter int NUM_SLICES = 4
) (
  input  logic [NUM_SLICES-1:0] prop,
  input  logic [NUM_SLICES-1:0] gen,
  input  logic                  carry_in,
  output logic [NUM_SLICES:0]   carry
);

  // Each carry is the OR of every lower generate term that can propagate up
  // to it, plus the incoming carry if all lower slices propagate.
  always_comb begin
    logic acc;
    logic run;
    carry[0] = carry_in;
    for (int i = 0; i < NUM_SLICES; i++) begin
      acc = gen[i];
      run = prop[i];
      for (int j = i - 1; j >= 0; j--) begin
        acc = acc | (run & gen[j]);
        run = run & prop[j];
      end
      carry[i+1] = acc | (run & carry_in);
    end
  end

endmodule

`default_nettype wire

// File: design/alu_slice.sv
`timescale 1ns/1ps
`default_nettype none

module alu_slice import alu_pkg::*; (
  input  logic [SLICE_WIDTH-1:0] a,
  input  logic [SLICE_WIDTH-1:0] b,
  input  alu_op_t                op,
  input  logic                   c_in,
  output logic [SLICE_WIDTH-1:0] out,
  output logic                   prop,
  output logic                   gen,
  output logic                   zero
);

  logic [SLICE_WIDTH-1:0] b_eff;
  logic [SLICE_WIDTH:0]   raw_sum;

  // Subtraction adds the inverted operand; the +1 arrives through c_in.
  assign b_eff   = (op == alu_sub) ? ~b : b;
  assign raw_sum = {1'b0, a} + {1'b0, b_eff};

  always_comb begin
    prop = 1'b0;
    gen  = 1'b0;
    out  = '0;
    case (op)
      alu_add, alu_sub: begin
        out  = raw_sum[SLICE_WIDTH-1:0] + {{(SLICE_WIDTH-1){1'b0}}, c_in};
        // Propagate and generate come from the carry-free sum only.
        prop = (raw_sum[SLICE_WIDTH-1:0] == {SLICE_WIDTH{1'b1}});
        gen  = raw_sum[SLICE_WIDTH];
      end
      alu_and: out = a & b;
      alu_or:  out = a | b;
      alu_xor: out = a ^ b;
      alu_not: out = ~a;
      alu_nop0: out = '0;
      alu_nop1: out = '0;
      default: out = '0;
    endcase
  end

  assign zero = (out == '0);

endmodule

`default_nettype wire

// File: design/stage_if.sv
`timescale 1ns/1ps
`default_nettype none

// Operation passed from the operand stage to the slice stage.
interface op_if import alu_pkg::*; #(
  parameter int NUM_SLICES = 4
) ();
  logic                            valid;
  alu_op_t                         op;
  logic [NUM_SLICES*SLICE_WIDTH-1:0] a;
  logic [NUM_SLICES*SLICE_WIDTH-1:0] b;

  modport src (output valid, op, a, b);
  modport dst (input valid, op, a, b);
endinterface

// Raw slice output passed from the slice stage to the flag stage.
interface result_if import alu_pkg::*; #(
  parameter int NUM_SLICES = 4
) ();
  logic                            valid;
  alu_op_t                         op;
  logic [NUM_SLICES*SLICE_WIDTH-1:0] result;
  logic                            carry_out;
  logic [NUM_SLICES-1:0]           slice_zero;
  logic                            a_msb;
  logic                            b_msb;

  modport src (output valid, op, result, carry_out, slice_zero, a_msb, b_msb);
  modport dst (input valid, op, result, carry_out, slice_zero, a_msb, b_msb);
endinterface

`default_nettype wire

// File: design/alu_pkg.sv
`default_nettype none

package alu_pkg;

  // Every slice is this many bits wide. The slice carry logic assumes four.
  localparam int SLICE_WIDTH = 4;

  typedef enum logic [2:0] {
    alu_add  = 3'd0,
    alu_sub  = 3'd1,
    alu_and  = 3'd2,
    alu_or   = 3'd3,
    alu_xor  = 3'd4,
    alu_not  = 3'd5,
    alu_nop0 = 3'd6,
    alu_nop1 = 3'd7
  } alu_op_t;

  // Status flags of the final result.
  typedef struct packed {
    logic zero;
    logic carry;
    logic negative;
    logic overflow;
  } alu_flags_t;

  // True for the two opcodes that go through the adder.
  function automatic logic is_arith(alu_op_t op);
    return (op == alu_add) || (op == alu_sub);
  endfunction

endpackage

`default_nettype wire
